// File: build.f
rtl/bp_pkg.sv
rtl/pred_table.sv
rtl/history_fold.sv
rtl/base_predictor.sv
rtl/tagged_bank.sv
rtl/provider_select.sv
rtl/tage_top.sv
tb/tage_props.sv
tb/tb_tage.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_tage
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_tage.sv
// TAGE predictor testbench
`timescale 1ns/1ns

module tb_tage;

    import bp_pkg::*;

    typedef enum logic {OP_PRED, OP_UPD} op_e;

    // One stimulus row; chain keeps the next row in the very next cycle
    typedef struct packed {
        op_e               op;
        logic [PC_W-1:0]   pc;
        logic              taken;
        logic              exp_taken;
        logic [PROV_W-1:0] exp_prov;
        logic              chain;
    } step_t;

    localparam logic [PC_W-1:0]   PC_A       = 32'h0000_1234;
    localparam logic [PC_W-1:0]   PC_B       = 32'h0000_5a71;
    localparam logic [PROV_W-1:0] PROV_BASE  = '0;
    localparam logic [PROV_W-1:0] PROV_TOP   = PROV_W'(NUM_BANKS_DEF);
    localparam int                WAIT_LIMIT = 20;

    logic      clk = 1'b0;
    logic      rst_n;
    pred_req_t pred_req;
    upd_req_t  upd_req;
    pred_res_t pred_res;

    step_t     steps [$];
    pred_res_t exp_q [$];
    int        due_q [$];
    int        row_q [$];

    int neg_count     = 0;
    int err_count     = 0;
    int timeout_count = 0;
    int extra_count   = 0;

    tage_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pred_req_i(pred_req),
        .upd_req_i (upd_req),
        .pred_res_o(pred_res)
    );

    always #50 clk = ~clk;

    task automatic add_step(input op_e op, input logic [PC_W-1:0] pc, input logic taken,
                            input logic exp_taken, input logic [PROV_W-1:0] exp_prov,
                            input logic chain);
        step_t s;
        s.op        = op;
        s.pc        = pc;
        s.taken     = taken;
        s.exp_taken = exp_taken;
        s.exp_prov  = exp_prov;
        s.chain     = chain;
        steps.push_back(s);
    endtask

    task automatic check_taken(input string name, input logic exp_taken, input logic act_taken);
        if (act_taken !== exp_taken) begin
            $display("ERR %s taken: expected %0b, actual %0b", name, exp_taken, act_taken);
            err_count++;
        end
    endtask

    task automatic check_provider(input string name, input logic [PROV_W-1:0] exp_prov,
                                  input pred_res_t res);
        if (res.provider !== exp_prov) begin
            $display("ERR %s provider: expected %0d, actual %0d", name, exp_prov, res.provider);
            err_count++;
        end
    endtask

    task automatic check_latency(input string name, input int exp_cycle, input int act_cycle);
        if (act_cycle != exp_cycle) begin
            $display("ERR %s latency: expected cycle %0d, actual cycle %0d",
                     name, exp_cycle, act_cycle);
            err_count++;
        end
    endtask

    task automatic wait_results(input int row);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout at row %0d: a prediction result never arrived", row);
            timeout_count++;
            exp_q.delete();
            due_q.delete();
            row_q.delete();
        end
    endtask

    // Results are sampled mid-cycle, matched in request order
    always @(negedge clk) begin
        pred_res_t exp_res;
        int        due;
        int        row;
        neg_count++;
        if (rst_n && pred_res.valid) begin
            if (exp_q.size() == 0) begin
                $display("A prediction result came out with no request pending");
                extra_count++;
            end else begin
                exp_res = exp_q.pop_front();
                due     = due_q.pop_front();
                row     = row_q.pop_front();
                check_taken($sformatf("row %0d", row), exp_res.taken, pred_res.taken);
                check_provider($sformatf("row %0d", row), exp_res.provider, pred_res);
                check_latency($sformatf("row %0d", row), due, neg_count);
            end
        end
    end

    initial begin
        step_t     s;
        pred_res_t expect_res;
        rst_n    = 1'b0;
        pred_req = '0;
        upd_req  = '0;

        // Fresh tables, base counters at 2
        add_step(OP_PRED, PC_A, 1'b0, 1'b1, PROV_BASE, 1'b0);
        add_step(OP_PRED, PC_B, 1'b0, 1'b1, PROV_BASE, 1'b0);
        // First not-taken allocates in every bank at weak taken
        add_step(OP_UPD, PC_A, 1'b0, 1'b0, PROV_BASE, 1'b0);
        add_step(OP_PRED, PC_A, 1'b0, 1'b1, PROV_TOP, 1'b0);
        // Bank counter drops below midpoint
        add_step(OP_UPD, PC_A, 1'b0, 1'b0, PROV_BASE, 1'b0);
        add_step(OP_PRED, PC_A, 1'b0, 1'b0, PROV_TOP, 1'b0);
        for (int k = 0; k < 5; k++) begin
            add_step(OP_UPD, PC_A, 1'b0, 1'b0, PROV_BASE, 1'b0);
        end
        add_step(OP_PRED, PC_A, 1'b0, 1'b0, PROV_TOP, 1'b0);
        // Taken update sets history bit 0, so every tag for A moves
        add_step(OP_UPD, PC_A, 1'b1, 1'b0, PROV_BASE, 1'b0);
        add_step(OP_PRED, PC_A, 1'b0, 1'b0, PROV_BASE, 1'b0);
        add_step(OP_PRED, PC_B, 1'b0, 1'b1, PROV_BASE, 1'b0);
        // Back-to-back requests
        add_step(OP_PRED, PC_A, 1'b0, 1'b0, PROV_BASE, 1'b1);
        add_step(OP_PRED, PC_B, 1'b0, 1'b1, PROV_BASE, 1'b1);
        add_step(OP_PRED, PC_A, 1'b0, 1'b0, PROV_BASE, 1'b0);

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < steps.size(); i++) begin
            s = steps[i];
            @(posedge clk);
            if (s.op == OP_PRED) begin
                pred_req <= '{valid: 1'b1, pc: s.pc};
                upd_req  <= '0;
                expect_res = '{valid: 1'b1, taken: s.exp_taken, provider: s.exp_prov};
                exp_q.push_back(expect_res);
                due_q.push_back(neg_count + 2);
                row_q.push_back(i);
            end else begin
                pred_req <= '0;
                upd_req  <= '{valid: 1'b1, pc: s.pc, taken: s.taken};
            end
            if (!s.chain) begin
                @(posedge clk);
                pred_req <= '0;
                upd_req  <= '0;
                wait_results(i);
            end
        end

        // Idle tail catches any stray result
        repeat (3) @(posedge clk);

        $display("Checks done: %0d value errors, %0d timeouts, %0d unexpected results",
                 err_count, timeout_count, extra_count);
        if (err_count + timeout_count + extra_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: tb/tage_props.sv
// Provider select protocol checks
`timescale 1ns/1ns

module tage_props (
    input logic              clk,
    input logic              rst_n,
    input logic              pred_valid_i,
    input bp_pkg::pred_res_t pred_res_i
);

    // Each request is answered on the next edge
    a_answer: assert property (@(posedge clk) disable iff (!rst_n)
        pred_valid_i |=> pred_res_i.valid)
        else $error("prediction request not answered one cycle later");

    // No result without a request one cycle earlier
    a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
        pred_res_i.valid |-> $past(pred_valid_i))
        else $error("prediction result without a request");

    a_reset_low: assert property (@(posedge clk) !rst_n |-> !pred_res_i.valid)
        else $error("prediction result valid during reset");

endmodule

bind provider_select tage_props props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pred_valid_i(pred_valid_i),
    .pred_res_i  (pred_res_o)
);

// File: rtl/tage_top.sv
// TAGE direction predictor top
`timescale 1ns/1ns

module tage_top #(
    parameter int NUM_BANKS = bp_pkg::NUM_BANKS_DEF,
    parameter int HIST_BASE = bp_pkg::HIST_BASE_DEF
) (
    input  logic              clk,
    input  logic              rst_n,
    input  bp_pkg::pred_req_t pred_req_i,
    input  bp_pkg::upd_req_t  upd_req_i,
    output bp_pkg::pred_res_t pred_res_o
);

    import bp_pkg::*;

    bank_hash_t [NUM_BANKS-1:0] pred_hash;
    bank_hash_t [NUM_BANKS-1:0] upd_hash;
    logic       [NUM_BANKS-1:0] bank_hit;
    logic       [NUM_BANKS-1:0] bank_taken;
    logic                       base_taken;

    history_fold #(
        .NUM_BANKS(NUM_BANKS),
        .HIST_BASE(HIST_BASE)
    ) u_hist (
        .clk        (clk),
        .rst_n      (rst_n),
        .upd_req_i  (upd_req_i),
        .pred_pc_i  (pred_req_i.pc),
        .pred_hash_o(pred_hash),
        .upd_hash_o (upd_hash)
    );

    base_predictor u_base (
        .clk      (clk),
        .rst_n    (rst_n),
        .pred_pc_i(pred_req_i.pc),
        .upd_req_i(upd_req_i),
        .taken_o  (base_taken)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        tagged_bank u_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .pred_hash_i(pred_hash[b]),
            .upd_hash_i (upd_hash[b]),
            .upd_valid_i(upd_req_i.valid),
            .upd_taken_i(upd_req_i.taken),
            .hit_o      (bank_hit[b]),
            .taken_o    (bank_taken[b])
        );
    end

    provider_select #(
        .NUM_BANKS(NUM_BANKS)
    ) u_sel (
        .clk         (clk),
        .rst_n       (rst_n),
        .pred_valid_i(pred_req_i.valid),
        .bank_hit_i  (bank_hit),
        .bank_taken_i(bank_taken),
        .base_taken_i(base_taken),
        .pred_res_o  (pred_res_o)
    );

endmodule

// File: rtl/provider_select.sv
// Longest-history provider selection
`timescale 1ns/1ns

module provider_select #(
    parameter int NUM_BANKS = bp_pkg::NUM_BANKS_DEF
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pred_valid_i,
    input  logic [NUM_BANKS-1:0] bank_hit_i,
    input  logic [NUM_BANKS-1:0] bank_taken_i,
    input  logic                 base_taken_i,
    output bp_pkg::pred_res_t    pred_res_o
);

    import bp_pkg::*;

    logic              sel_taken;
    logic [PROV_W-1:0] sel_prov;
    logic              valid_q;
    logic              taken_q;
    logic [PROV_W-1:0] prov_q;

    // Higher banks see longer history, so the last hit wins
    always_comb begin
        sel_taken = base_taken_i;
        sel_prov  = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (bank_hit_i[i]) begin
                sel_taken = bank_taken_i[i];
                sel_prov  = PROV_W'(i + 1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pred_valid_i;
        end
    end

    // Result fields only load with a request
    always_ff @(posedge clk) begin
        if (pred_valid_i) begin
            taken_q <= sel_taken;
            prov_q  <= sel_prov;
        end
    end

    assign pred_res_o = '{valid: valid_q, taken: taken_q, provider: prov_q};

endmodule

// File: rtl/tagged_bank.sv
// Tagged predictor bank
`timescale 1ns/1ns

module tagged_bank (
    input  logic               clk,
    input  logic               rst_n,
    // Hashes for the prediction and the update
    input  bp_pkg::bank_hash_t pred_hash_i,
    input  bp_pkg::bank_hash_t upd_hash_i,
    input  logic               upd_valid_i,
    input  logic               upd_taken_i,
    output logic               hit_o,
    output logic               taken_o
);

    import bp_pkg::*;

    tag_entry_t pred_entry;
    tag_entry_t upd_entry;
    tag_entry_t next_entry;
    logic       upd_match;

    pred_table #(
        .entry_t  (tag_entry_t),
        .DEPTH_W  (IDX_W),
        .RESET_VAL(TAG_RESET)
    ) u_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_idx_i (pred_hash_i.idx),
        .rd_data_o(pred_entry),
        .lk_idx_i (upd_hash_i.idx),
        .lk_data_o(upd_entry),
        .wr_en_i  (upd_valid_i),
        .wr_idx_i (upd_hash_i.idx),
        .wr_data_i(next_entry)
    );

    // Prediction side
    assign hit_o   = (pred_entry.tag == pred_hash_i.tag);
    assign taken_o = pred_entry.ctr[CTR_W-1];

    assign upd_match = (upd_entry.tag == upd_hash_i.tag);

    // Train on a tag match, otherwise take the entry over
    always_comb begin
        next_entry = upd_entry;
        if (upd_match) begin
            case (upd_entry.ctr)
                {CTR_W{1'b0}}: begin
                    if (upd_taken_i) begin
                        next_entry.ctr = upd_entry.ctr + 1'b1;
                    end
                end
                {CTR_W{1'b1}}: begin
                    if (!upd_taken_i) begin
                        next_entry.ctr = upd_entry.ctr - 1'b1;
                    end
                end
                default: begin
                    if (upd_taken_i) begin
                        next_entry.ctr = upd_entry.ctr + 1'b1;
                    end else begin
                        next_entry.ctr = upd_entry.ctr - 1'b1;
                    end
                end
            endcase
        end else begin
            // New owner starts at weak taken
            next_entry.tag = upd_hash_i.tag;
            next_entry.ctr = CTR_WEAK;
        end
    end

endmodule

// File: rtl/base_predictor.sv
// Bimodal base predictor
`timescale 1ns/1ns

module base_predictor (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [bp_pkg::PC_W-1:0] pred_pc_i,
    input  bp_pkg::upd_req_t        upd_req_i,
    output logic                    taken_o
);

    import bp_pkg::*;

    base_entry_t pred_entry;
    base_entry_t upd_entry;
    base_entry_t next_entry;

    pred_table #(
        .entry_t  (base_entry_t),
        .DEPTH_W  (IDX_W),
        .RESET_VAL(BASE_RESET)
    ) u_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_idx_i (pred_pc_i[IDX_W-1:0]),
        .rd_data_o(pred_entry),
        .lk_idx_i (upd_req_i.pc[IDX_W-1:0]),
        .lk_data_o(upd_entry),
        .wr_en_i  (upd_req_i.valid),
        .wr_idx_i (upd_req_i.pc[IDX_W-1:0]),
        .wr_data_i(next_entry)
    );

    // Saturating 2-bit counter
    always_comb begin
        next_entry = upd_entry;
        if (upd_req_i.taken) begin
            if (upd_entry.ctr != 2'b11) begin
                next_entry.ctr = upd_entry.ctr + 2'd1;
            end
        end else begin
            if (upd_entry.ctr != 2'b00) begin
                next_entry.ctr = upd_entry.ctr - 2'd1;
            end
        end
    end

    assign taken_o = pred_entry.ctr[1];

endmodule

// File: rtl/history_fold.sv
// Global history and per-bank hashing
`timescale 1ns/1ns

module history_fold #(
    parameter int NUM_BANKS = bp_pkg::NUM_BANKS_DEF,
    parameter int HIST_BASE = bp_pkg::HIST_BASE_DEF
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  bp_pkg::upd_req_t                      upd_req_i,
    input  logic [bp_pkg::PC_W-1:0]               pred_pc_i,
    output bp_pkg::bank_hash_t [NUM_BANKS-1:0]    pred_hash_o,
    output bp_pkg::bank_hash_t [NUM_BANKS-1:0]    upd_hash_o
);

    import bp_pkg::*;

    logic [HIST_W-1:0] ghist;

    // XOR the history down onto w bits, result in the low w bits
    function automatic logic [HIST_W-1:0] fold(input logic [HIST_W-1:0] h, input int w);
        logic [HIST_W-1:0] r;
        r = '0;
        for (int j = 0; j < HIST_W; j++) begin
            r[j % w] = r[j % w] ^ h[j];
        end
        return r;
    endfunction

    function automatic bank_hash_t hash(input logic [PC_W-1:0] pc,
                                        input logic [HIST_W-1:0] slice);
        logic [HIST_W-1:0] f_idx;
        logic [HIST_W-1:0] f_tag;
        logic [HIST_W-1:0] f_tag2;
        bank_hash_t        h;
        f_idx  = fold(slice, IDX_W);
        f_tag  = fold(slice, TAG_W);
        f_tag2 = fold(slice, TAG_W - 1);
        h.idx  = f_idx[IDX_W-1:0] ^ pc[IDX_W-1:0] ^ pc[2*IDX_W-1:IDX_W];
        h.tag  = pc[TAG_W-1:0] ^ f_tag[TAG_W-1:0] ^ {f_tag2[TAG_W-2:0], 1'b0};
        return h;
    endfunction

    // Shift in the outcome on every resolved branch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghist <= '0;
        end else if (upd_req_i.valid) begin
            ghist <= {ghist[HIST_W-2:0], upd_req_i.taken};
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_fold
        // Bank b looks at HIST_BASE << b history bits
        localparam int LEN = HIST_BASE << b;

        logic [HIST_W-1:0] slice;

        always_comb begin
            for (int k = 0; k < HIST_W; k++) begin
                slice[k] = (k < LEN) ? ghist[k] : 1'b0;
            end
        end

        assign pred_hash_o[b] = hash(pred_pc_i, slice);
        assign upd_hash_o[b]  = hash(upd_req_i.pc, slice);
    end

endmodule

// File: rtl/pred_table.sv
// Generic predictor table storage
`timescale 1ns/1ns

module pred_table #(
    parameter type    entry_t   = logic,
    parameter int     DEPTH_W   = 8,
    parameter entry_t RESET_VAL = entry_t'('0)
) (
    input  logic               clk,
    input  logic               rst_n,
    // Prediction read
    input  logic [DEPTH_W-1:0] rd_idx_i,
    output entry_t             rd_data_o,
    // Update lookup
    input  logic [DEPTH_W-1:0] lk_idx_i,
    output entry_t             lk_data_o,
    // Update write
    input  logic               wr_en_i,
    input  logic [DEPTH_W-1:0] wr_idx_i,
    input  entry_t             wr_data_i
);

    localparam int DEPTH = 1 << DEPTH_W;

    entry_t mem [DEPTH];

    // Both reads are combinational and see the state before this edge
    assign rd_data_o = mem[rd_idx_i];
    assign lk_data_o = mem[lk_idx_i];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

// File: rtl/bp_pkg.sv
// Branch predictor shared types
package bp_pkg;

    // Widths
    localparam int PC_W   = 32;
    localparam int HIST_W = 32;
    localparam int IDX_W  = 8;
    localparam int TAG_W  = 8;
    localparam int CTR_W  = 3;
    localparam int PROV_W = 2;

    // Bank geometry defaults for the top level
    localparam int NUM_BANKS_DEF = 3;
    localparam int HIST_BASE_DEF = 4;

    // Weak taken, only the top counter bit set
    localparam logic [CTR_W-1:0] CTR_WEAK = CTR_W'(1 << (CTR_W - 1));

    typedef struct packed {
        logic [1:0] ctr;
    } base_entry_t;

    typedef struct packed {
        logic [CTR_W-1:0] ctr;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    localparam base_entry_t BASE_RESET = '{ctr: 2'd2};
    localparam tag_entry_t  TAG_RESET  = '{ctr: CTR_WEAK, tag: '0};

    typedef struct packed {
        logic            valid;
        logic [PC_W-1:0] pc;
    } pred_req_t;

    typedef struct packed {
        logic            valid;
        logic [PC_W-1:0] pc;
        logic            taken;
    } upd_req_t;

    // Provider 0 is the base table, i+1 is tagged bank i
    typedef struct packed {
        logic              valid;
        logic              taken;
        logic [PROV_W-1:0] provider;
    } pred_res_t;

    typedef struct packed {
        logic [IDX_W-1:0] idx;
        logic [TAG_W-1:0] tag;
    } bank_hash_t;

endpackage
